//--- design/gru_pkg.sv
package gru_pkg;

	////////////////////////////////////////
	// fixed point Q16.16

	localparam int frac_bits = 16;

	typedef logic signed [31:0] fix_t;
	typedef logic signed [63:0] prod_t;

	localparam fix_t fix_one = fix_t'(1 << frac_bits);
	localparam fix_t fix_half = fix_t'(1 << (frac_bits - 1));

	// lane, gate (z, r, cand), then bias, input weights, recurrent weights
	localparam weight_file = "gru_weights.mem";

	typedef enum logic {
		pass_gates,
		pass_cand
	} pass_t;

	typedef enum logic [1:0] {
		st_load,
		st_wait,
		st_gates,
		st_cand
	} feed_state_t;

	// one element broadcast to all lanes
	typedef struct packed {
		logic       valid;
		pass_t      pass;
		logic       rec;
		logic [3:0] idx;
		fix_t       value;
		fix_t       gate_r;
		logic       last;
	} bcast_t;

	////////////////////////////////////////
	// arithmetic

	// keeps bits 47:16 of the full product
	function automatic fix_t fix_mul(fix_t a, fix_t b);
		prod_t p;
		p = prod_t'(a) * prod_t'(b);
		return fix_t'(p[frac_bits +: 32]);
	endfunction

	function automatic fix_t hard_tanh(fix_t a);
		fix_t y;
		if (a > fix_one) begin
			y = fix_one;
		end else if (a < -fix_one) begin
			y = -fix_one;
		end else begin
			y = a;
		end
		return y;
	endfunction

	// sigmoid(x) ~ tanh(x/2)/2 + 0.5
	function automatic fix_t hard_sigmoid(fix_t a);
		fix_t t;
		t = hard_tanh(a >>> 1);
		return (t >>> 1) + fix_half;
	endfunction

endpackage

//--- design/gru_feeder.sv
module gru_feeder import gru_pkg::*; #(
	parameter int num_inputs = 4,
	parameter int num_neurons = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  fix_t                   in_data,
	input  logic                   busy,
	input  fix_t [num_neurons-1:0] r_vec,
	output bcast_t                 bcast
);

	localparam int vec_len = num_inputs + num_neurons;
	localparam int cnt_w = vec_len > 1 ? $clog2(vec_len) : 1;

	feed_state_t state;
	logic [cnt_w-1:0] cnt;
	logic cnt_last;
	logic el_valid;
	logic el_rec;
	logic step;

	// x in the low entries, h above them, same order as the broadcast
	fix_t vec_buf [vec_len];

	assign in_ready = (state == st_load);
	assign el_valid = (state == st_gates) || (state == st_cand);
	assign el_rec = int'(cnt) >= num_inputs;
	assign cnt_last = (cnt == cnt_w'(vec_len - 1));

	// one count per accepted beat or per broadcast element
	assign step = in_ready ? in_valid : el_valid;

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			vec_buf[cnt] <= in_data;
		end
	end

	////////////////////////////////////////
	// sequencing

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_load;
			cnt <= '0;
		end else begin
			if (step) begin
				cnt <= cnt_last ? '0 : cnt + 1'b1;
			end
			case (state)
				st_load: begin
					if (step && cnt_last) begin
						state <= st_wait;
					end
				end
				st_wait: begin
					// collector still draining the previous state
					if (!busy) begin
						state <= st_gates;
					end
				end
				st_gates: begin
					if (cnt_last) begin
						state <= st_cand;
					end
				end
				st_cand: begin
					if (cnt_last) begin
						state <= st_load;
					end
				end
				default: state <= st_load;
			endcase
		end
	end

	////////////////////////////////////////
	// broadcast element

	always_comb begin
		bcast = '0;
		bcast.valid = el_valid;
		bcast.pass = (state == st_cand) ? pass_cand : pass_gates;
		bcast.rec = el_rec;
		bcast.idx = el_rec ? 4'(int'(cnt) - num_inputs) : 4'(cnt);
		bcast.value = vec_buf[cnt];
		bcast.last = cnt_last;
		// r_k rides beside h_k in the candidate pass
		for (int k = 0; k < num_neurons; k++) begin
			if (el_rec && state == st_cand && int'(cnt) == num_inputs + k) begin
				bcast.gate_r = r_vec[k];
			end
		end
	end

endmodule

//--- design/gru_neuron.sv
module gru_neuron import gru_pkg::*; #(
	parameter int lane_id = 0,
	parameter int num_inputs = 4,
	parameter int num_neurons = 4
) (
	input  logic   clk,
	input  logic   rst,
	input  bcast_t bcast,
	output fix_t   r,
	output fix_t   h_new,
	output logic   h_new_valid
);

	localparam int gate_words = 1 + num_inputs + num_neurons;
	localparam int lane_words = 3 * gate_words;
	localparam int file_words = num_neurons * lane_words;
	localparam int aw = file_words > 1 ? $clog2(file_words) : 1;

	// slice of this lane in the weight image
	localparam int lane_base = lane_id * lane_words;
	localparam bit [aw-1:0] bias_z = aw'(lane_base);
	localparam bit [aw-1:0] bias_r = aw'(lane_base + gate_words);
	localparam bit [aw-1:0] bias_c = aw'(lane_base + 2 * gate_words);

	fix_t wmem [file_words];

	int el_off;
	logic first;
	logic [aw-1:0] a_z;
	logic [aw-1:0] a_r;
	logic [aw-1:0] a_c;
	fix_t p_z;
	fix_t p_r;
	fix_t p_hw;
	fix_t p_c;
	fix_t s_z;
	fix_t s_r;
	fix_t s_c;
	fix_t acc_z;
	fix_t acc_r;
	fix_t acc_c;
	fix_t z;
	fix_t h_self;

	initial begin
		$readmemh(weight_file, wmem);
	end

	////////////////////////////////////////
	// multiply-accumulate

	always_comb begin
		first = !bcast.rec && bcast.idx == 4'd0;
		el_off = bcast.rec ? 1 + num_inputs + int'(bcast.idx) : 1 + int'(bcast.idx);
		a_z = aw'(int'(bias_z) + el_off);
		a_r = aw'(int'(bias_r) + el_off);
		a_c = aw'(int'(bias_c) + el_off);

		p_z = fix_mul(wmem[a_z], bcast.value);
		p_r = fix_mul(wmem[a_r], bcast.value);
		// recurrent candidate term truncated twice, w*h then *r
		p_hw = fix_mul(wmem[a_c], bcast.value);
		p_c = bcast.rec ? fix_mul(p_hw, bcast.gate_r) : p_hw;

		// bias enters with the first element
		s_z = (first ? wmem[bias_z] : acc_z) + p_z;
		s_r = (first ? wmem[bias_r] : acc_r) + p_r;
		s_c = (first ? wmem[bias_c] : acc_c) + p_c;
	end

	always_ff @(posedge clk) begin
		if (bcast.valid && bcast.pass == pass_gates) begin
			acc_z <= s_z;
			acc_r <= s_r;
			if (bcast.rec && bcast.idx == 4'(lane_id)) begin
				h_self <= bcast.value;
			end
			if (bcast.last) begin
				z <= hard_sigmoid(s_z);
				r <= hard_sigmoid(s_r);
			end
		end
		if (bcast.valid && bcast.pass == pass_cand) begin
			acc_c <= s_c;
			// h' = z*h + (1 - z)*tanh(cand)
			if (bcast.last) begin
				h_new <= fix_mul(z, h_self) + fix_mul(fix_one - z, hard_tanh(s_c));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			h_new_valid <= 1'b0;
		end else begin
			h_new_valid <= bcast.valid && bcast.pass == pass_cand && bcast.last;
		end
	end

endmodule

//--- design/gru_collector.sv
module gru_collector import gru_pkg::*; #(
	parameter int num_neurons = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   h_new_valid,
	input  fix_t [num_neurons-1:0] h_vec,
	output logic                   busy,
	output logic                   out_valid,
	input  logic                   out_ready,
	output fix_t                   out_data
);

	localparam int iw = num_neurons > 1 ? $clog2(num_neurons) : 1;

	fix_t [num_neurons-1:0] h_hold;
	logic [iw-1:0] rd_idx;
	logic rd_last;

	assign rd_last = (rd_idx == iw'(num_neurons - 1));

	// stable while stalled, index only moves on a handshake
	assign out_data = h_hold[rd_idx];

	always_ff @(posedge clk) begin
		if (h_new_valid) begin
			h_hold <= h_vec;
		end
	end

	////////////////////////////////////////
	// output walk

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			out_valid <= 1'b0;
			rd_idx <= '0;
		end else if (h_new_valid) begin
			busy <= 1'b1;
			out_valid <= 1'b1;
			rd_idx <= '0;
		end else if (out_valid && out_ready) begin
			if (rd_last) begin
				busy <= 1'b0;
				out_valid <= 1'b0;
				rd_idx <= '0;
			end else begin
				rd_idx <= rd_idx + 1'b1;
			end
		end
	end

endmodule

//--- design/gru_top.sv
module gru_top import gru_pkg::*; #(
	parameter int num_inputs = 4,
	parameter int num_neurons = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  fix_t in_data,
	output logic in_ready,
	output logic out_valid,
	output fix_t out_data,
	input  logic out_ready
);

	bcast_t bcast;
	fix_t [num_neurons-1:0] r_vec;
	fix_t [num_neurons-1:0] h_vec;
	logic [num_neurons-1:0] lane_valid;
	logic h_done;
	logic busy;

	gru_feeder #(
		.num_inputs(num_inputs),
		.num_neurons(num_neurons)
	) u_feeder (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.busy(busy),
		.r_vec(r_vec),
		.bcast(bcast)
	);

	// lanes run in lockstep
	for (genvar i = 0; i < num_neurons; i++) begin : g_lane
		gru_neuron #(
			.lane_id(i),
			.num_inputs(num_inputs),
			.num_neurons(num_neurons)
		) u_neuron (
			.clk(clk),
			.rst(rst),
			.bcast(bcast),
			.r(r_vec[i]),
			.h_new(h_vec[i]),
			.h_new_valid(lane_valid[i])
		);
	end

	assign h_done = &lane_valid;

	gru_collector #(
		.num_neurons(num_neurons)
	) u_collector (
		.clk(clk),
		.rst(rst),
		.h_new_valid(h_done),
		.h_vec(h_vec),
		.busy(busy),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

endmodule

//--- tests/gru_chk.sv
module gru_chk import gru_pkg::*; #(
	parameter int num_inputs = 4,
	parameter int num_neurons = 4
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input fix_t out_data
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int vec_len = num_inputs + num_neurons;
	// one wait cycle plus both broadcast passes
	localparam int lock_cycles = 2 * vec_len + 1;

	int beat;
	int lock;
	// number of assertion failures so far
	int fail_count = 0;

	always_ff @(posedge clk) begin
		if (rst) begin
			beat <= 0;
			lock <= 0;
		end else begin
			if (lock != 0) begin
				lock <= lock - 1;
			end
			if (in_valid && in_ready) begin
				if (beat == vec_len - 1) begin
					beat <= 0;
					lock <= lock_cycles;
				end else begin
					beat <= beat + 1;
				end
			end
		end
	end

	a_out_stable: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> $stable(out_data))
		else begin
			$error("out_data changed while the output was stalled");
			fail_count++;
		end

	a_out_reset: assert property (@(posedge clk) rst |=> !out_valid)
		else begin
			$error("out_valid high right after reset");
			fail_count++;
		end

	a_in_locked: assert property (@(posedge clk) disable iff (rst)
		lock != 0 |-> !in_ready)
		else begin
			$error("in_ready high while a step is still being computed");
			fail_count++;
		end

endmodule

//--- tests/gru_tb.sv
module gru_tb import gru_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ni = 4;
	localparam int nn = 4;
	localparam int gate_words = 1 + ni + nn;
	localparam int lane_words = 3 * gate_words;
	localparam int file_words = nn * lane_words;
	localparam int clk_period = 20;
	localparam int num_vectors = 39;
	localparam fix_t q_one = 32'sh0001_0000;
	localparam fix_t q_half = 32'sh0000_8000;

	typedef fix_t [ni-1:0] xvec_t;
	typedef fix_t [nn-1:0] hvec_t;
	typedef enum {rdy_high, rdy_random, rdy_low} ready_mode_t;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	fix_t in_data;
	logic out_valid;
	fix_t out_data;
	logic out_ready;

	ready_mode_t ready_mode;
	fix_t ref_w [file_words];
	fix_t exp_q [$];
	int out_idx = 0;
	logic stalled = 1'b0;
	fix_t held_data;

	gru_top u_dut (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_ready(out_ready)
	);

	bind gru_top gru_chk #(
		.num_inputs(num_inputs),
		.num_neurons(num_neurons)
	) u_chk (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

	always #(clk_period / 2) clk = ~clk;

	////////////////////////////////////////
	// reference model

	function automatic fix_t q_mul(input fix_t a, input fix_t b);
		longint p;
		p = longint'(a) * longint'(b);
		return fix_t'(p >>> 16);
	endfunction

	function automatic fix_t clamp_unit(input fix_t a);
		if (a > q_one) begin
			return q_one;
		end else if (a < -q_one) begin
			return -q_one;
		end
		return a;
	endfunction

	function automatic fix_t sig_approx(input fix_t a);
		fix_t t;
		t = clamp_unit(a >>> 1);
		return (t >>> 1) + q_half;
	endfunction

	function automatic hvec_t gru_ref(input xvec_t x, input hvec_t h);
		fix_t z [nn];
		fix_t r [nn];
		fix_t acc_z;
		fix_t acc_r;
		fix_t acc_c;
		hvec_t h_out;
		int b;
		for (int i = 0; i < nn; i++) begin
			b = i * lane_words;
			acc_z = ref_w[b];
			acc_r = ref_w[b + gate_words];
			for (int j = 0; j < ni; j++) begin
				acc_z = acc_z + q_mul(ref_w[b + 1 + j], x[j]);
				acc_r = acc_r + q_mul(ref_w[b + gate_words + 1 + j], x[j]);
			end
			for (int k = 0; k < nn; k++) begin
				acc_z = acc_z + q_mul(ref_w[b + 1 + ni + k], h[k]);
				acc_r = acc_r + q_mul(ref_w[b + gate_words + 1 + ni + k], h[k]);
			end
			z[i] = sig_approx(acc_z);
			r[i] = sig_approx(acc_r);
		end
		// candidate needs every lane's r
		for (int i = 0; i < nn; i++) begin
			b = i * lane_words + 2 * gate_words;
			acc_c = ref_w[b];
			for (int j = 0; j < ni; j++) begin
				acc_c = acc_c + q_mul(ref_w[b + 1 + j], x[j]);
			end
			for (int k = 0; k < nn; k++) begin
				acc_c = acc_c + q_mul(q_mul(ref_w[b + 1 + ni + k], h[k]), r[k]);
			end
			h_out[i] = q_mul(z[i], h[i]) + q_mul(q_one - z[i], clamp_unit(acc_c));
		end
		return h_out;
	endfunction

	////////////////////////////////////////
	// checks

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_state(input int idx, input fix_t got, input fix_t exp);
		if (got !== exp) begin
			fail_now($sformatf("[FAIL] t=%0t element %0d: got %h, expected %h",
				$time, idx, got, exp));
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("[FAIL] t=%0t %s: got %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			fail_now($sformatf("[FAIL] t=%0t output latency: got %0d cycles, expected %0d",
				$time, got, exp));
		end
	endtask

	// compare process, outputs sampled mid cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (stalled) begin
				check_flag("out_valid during stall", out_valid, 1'b1);
				check_state(out_idx, out_data, held_data);
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					fail_now("An output beat arrived while no vector was pending.");
				end else begin
					check_state(out_idx, out_data, exp_q.pop_front());
					out_idx = (out_idx + 1) % nn;
				end
			end
			stalled = out_valid && !out_ready;
			held_data = out_data;
		end
	end

	// handshake assertions of the bound checker
	always @(negedge clk) begin
		if (u_dut.u_chk.fail_count != 0) begin
			fail_now("A handshake assertion in the bound checker failed.");
		end
	end

	always @(posedge clk) begin
		#2;
		case (ready_mode)
			rdy_high: out_ready = 1'b1;
			rdy_random: out_ready = ($urandom % 2) == 0;
			default: out_ready = 1'b0;
		endcase
	end

	initial begin
		#(num_vectors * 200 * clk_period);
		fail_now("The run timed out before all expected outputs arrived.");
	end

	////////////////////////////////////////
	// stimulus

	function automatic fix_t rand_small();
		// within +-1.0
		return fix_t'(int'($urandom % 32'h2_0001) - 65536);
	endfunction

	function automatic fix_t rand_big();
		fix_t mag;
		mag = fix_t'(32'h4_0001 + $urandom % 32'h4_0000);
		return ($urandom % 2) ? -mag : mag;
	endfunction

	function automatic xvec_t rand_x(input bit big);
		xvec_t x;
		for (int j = 0; j < ni; j++) begin
			x[j] = big ? rand_big() : rand_small();
		end
		return x;
	endfunction

	function automatic hvec_t rand_h(input bit big);
		hvec_t h;
		for (int k = 0; k < nn; k++) begin
			h[k] = big ? rand_big() : rand_small();
		end
		return h;
	endfunction

	task automatic send_beat(input fix_t d);
		bit accepted;
		in_valid = 1'b1;
		in_data = d;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = in_ready;
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
	endtask

	task automatic run_step(input xvec_t x, input hvec_t h, output hvec_t h_next);
		h_next = gru_ref(x, h);
		for (int i = 0; i < nn; i++) begin
			exp_q.push_back(h_next[i]);
		end
		for (int j = 0; j < ni; j++) begin
			send_beat(x[j]);
		end
		for (int k = 0; k < nn; k++) begin
			send_beat(h[k]);
		end
	endtask

	task automatic drain_outputs();
		do begin
			@(posedge clk);
		end while (exp_q.size() != 0);
		#2;
	endtask

	////////////////////////////////////////
	// behaviors

	task automatic first_vector();
		hvec_t h_next;
		@(negedge clk);
		check_flag("out_valid after reset", out_valid, 1'b0);
		@(posedge clk);
		#2;
		run_step(rand_x(1'b0), '0, h_next);
		drain_outputs();
	endtask

	task automatic recurrent_chain();
		hvec_t h;
		hvec_t h_next;
		h = '0;
		for (int n = 0; n < 20; n++) begin
			run_step(rand_x(1'b0), h, h_next);
			h = h_next;
		end
		drain_outputs();
	endtask

	task automatic clamping_inputs();
		hvec_t h_next;
		for (int n = 0; n < 4; n++) begin
			run_step(rand_x(1'b1), rand_h(1'b1), h_next);
		end
		drain_outputs();
	endtask

	task automatic random_stall();
		hvec_t h;
		hvec_t h_next;
		ready_mode = rdy_random;
		h = rand_h(1'b0);
		for (int n = 0; n < 10; n++) begin
			run_step(rand_x(1'b0), h, h_next);
			h = h_next;
		end
		drain_outputs();
		ready_mode = rdy_high;
	endtask

	task automatic output_backpressure();
		hvec_t h_next;
		ready_mode = rdy_low;
		fork
			begin
				for (int n = 0; n < 3; n++) begin
					run_step(rand_x(1'b0), rand_h(1'b0), h_next);
				end
			end
			begin
				repeat (300) @(posedge clk);
				@(negedge clk);
				check_flag("in_ready with output stalled", in_ready, 1'b0);
				ready_mode = rdy_high;
			end
		join
		drain_outputs();
	endtask

	task automatic output_latency();
		hvec_t h_next;
		int lat;
		run_step(rand_x(1'b0), rand_h(1'b0), h_next);
		lat = 0;
		do begin
			@(posedge clk);
			lat++;
			@(negedge clk);
		end while (!out_valid && lat < 100);
		check_latency(lat, 2 * (ni + nn) + 2);
		drain_outputs();
	endtask

	initial begin
		void'($urandom(32'h3ed2));
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		ready_mode = rdy_high;
		$readmemh("gru_weights.mem", ref_w);
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;

		first_vector();
		recurrent_chain();
		clamping_inputs();
		random_stall();
		output_backpressure();
		output_latency();

		// no stray beats after the last vector
		repeat (2 * (ni + nn) + 4) @(posedge clk);
		if (u_dut.u_chk.fail_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			fail_now("A handshake assertion in the bound checker failed.");
		end
	end

endmodule

//--- project.f
design/gru_pkg.sv
design/gru_feeder.sv
design/gru_neuron.sv
design/gru_collector.sv
design/gru_top.sv
tests/gru_chk.sv
tests/gru_tb.sv

//--- run.sh
#!/bin/sh
# compile the GRU testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module gru_tb -o gru_sim

out=$(./obj_dir/gru_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1

//--- gru_weights.mem
// signed Q16.16 hex, one word per line; for lane 0..3, gate z, r, cand:
// bias, input weights x0..x3, recurrent weights h0..h3
00001800
00004CCD
FFFFB333
00002000
FFFFE666
00003333
FFFFD99A
00001000
00005000
FFFFF000
0000399A
00006666
FFFFC000
00000CCD
FFFFE000
00004000
00002666
FFFFCCCD
00000800
0000A000
FFFF8CCD
00004CCD
00003000
0000599A
FFFFB99A
FFFFF333
00007333
FFFFE800
FFFFC666
00005333
00001333
FFFFD000
00006000
0000199A
FFFFA666
00002CCD
00002000
00003CCD
FFFFB000
00007000
FFFFEB85
FFFFC99A
00000A3D
00004333
FFFFF99A
FFFFF800
FFFF999A
0000B333
FFFFD333
00006CCD
00001EB8
FFFFA000
00003666
00005C29
00000C00
00002E14
FFFFCA3D
0000628F
FFFFF0A4
00004A3D
FFFFE3D7
00003852
FFFFB852
FFFFE400
000051EC
0000147B
FFFFA8F6
00003D71
FFFFD70A
00006B85
FFFFF5C3
00001C29
00001400
FFFF8A3D
000075C3
00002B85
FFFFC28F
0000970A
0000051F
FFFFB5C3
00004F5C
FFFFF400
00003AE1
00000F5C
FFFFCF5C
00005EB8
FFFFE8F6
000023D7
FFFF9EB8
000045C3
00001C00
FFFFDEB8
00004851
00002147
FFFFB0A4
00006147
FFFFF28F
000033D7
FFFFC7AE
FFFFEC00
00008F5C
FFFF9C29
00003EB8
000011EC
FFFFA3D7
00006E14
000028F6
FFFFD47B
